// ==== tb/sa_tests.txt ====
# per job: K IDLE (idle cycles before the job), then K lines of HEIGHT A values and WIDTH B values,
# then HEIGHT lines of WIDTH expected C values, row 0 first.
11 2
1 2 3 4 1 3 5 7
2 4 6 8 2 6 10 14
1 2 3 4 1 3 5 7
2 4 6 8 2 6 10 14
1 2 3 4 1 3 5 7
2 4 6 8 2 6 10 14
1 2 3 4 1 3 5 7
2 4 6 8 2 6 10 14
1 2 3 4 1 3 5 7
2 4 6 8 2 6 10 14
1 2 3 4 1 3 5 7
26 78 130 182
52 156 260 364
78 234 390 546
104 312 520 728
11 0
-128 127 -128 127 -128 127 127 -128
127 -128 1 -1 127 -128 -1 1
-128 127 -128 127 -128 127 127 -128
127 -128 1 -1 127 -128 -1 1
-128 127 -128 127 -128 127 127 -128
127 -128 1 -1 127 -128 -1 1
-128 127 -128 127 -128 127 127 -128
127 -128 1 -1 127 -128 -1 1
-128 127 -128 127 -128 127 127 -128
127 -128 1 -1 127 -128 -1 1
-128 127 -128 127 -128 127 127 -128
178949 -178816 -98171 98939
-178816 178694 97414 -98176
98939 -98176 -97541 98309
-98171 97414 96779 -97541
12 5
3 -2 1 5 -1 4 2 -3
3 -2 1 5 -1 4 2 -3
3 -2 1 5 -1 4 2 -3
3 -2 1 5 -1 4 2 -3
3 -2 1 5 -1 4 2 -3
3 -2 1 5 -1 4 2 -3
6 -4 2 10 1 -4 -2 3
6 -4 2 10 1 -4 -2 3
6 -4 2 10 1 -4 -2 3
6 -4 2 10 1 -4 -2 3
6 -4 2 10 1 -4 -2 3
6 -4 2 10 1 -4 -2 3
18 -72 -36 54
-12 48 24 -36
6 -24 -12 18
30 -120 -60 90

// ==== filelist.f ====
common/sa_geom_pkg.sv
common/sa_ctrl_pkg.sv
pe/sa_pe.sv
array/sa_array.sv
hdl/skew_buffer.sv
hdl/sa_sequencer.sv
hdl/sa_top.sv
tb/sa_tb.sv

// ==== tb/sa_tb.sv ====
`timescale 1ns/100ps

module sa_tb;

    import sa_geom_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int    PERIOD    = 4;
    localparam int    LAT       = HEIGHT + WIDTH; // in_last sample to first valid row.
    localparam string TEST_FILE = "tb/sa_tests.txt";

    logic  clk;
    logic  reset_i;
    logic  in_valid_i;
    logic  in_last_i;
    data_t a_col_i [HEIGHT];
    data_t b_row_i [WIDTH];
    acc_t  c_row_o [WIDTH];
    logic  c_valid_o;

    // jobs from the data file.
    int    job_k[$];
    int    job_idle[$];
    data_t a_mem[$];   // HEIGHT values per beat.
    data_t b_mem[$];   // WIDTH values per beat.
    acc_t  exp_mem[$]; // HEIGHT*WIDTH per job, row major.

    // what the collector saw.
    acc_t  got_rows[$];
    int    last_cycle[$];
    int    rise_cycle[$];
    int    high_len[$];

    int    checks = 0;
    int    errors = 0;
    int    limit  = 0;
    bit    ok;

    sa_top dut0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .in_last_i  (in_last_i),
        .a_col_i    (a_col_i),
        .b_row_i    (b_row_i),
        .c_row_o    (c_row_o),
        .c_valid_o  (c_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic check_value(input longint got, input longint exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic load_tests(output bit good);
        int fd;
        int r;
        int k;
        int idle;
        int v;
        int beats;
        logic [8*160-1:0] line_buf;
        good  = 1'b0;
        beats = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            return;
        end
        r = $fgets(line_buf, fd); // column description lines.
        r = $fgets(line_buf, fd);
        good = 1'b1;
        while ($fscanf(fd, "%d %d", k, idle) == 2) begin
            if (k < MIN_K) begin
                $display("job %0d has K = %0d, below the minimum of %0d", job_k.size(), k, MIN_K);
                good = 1'b0;
            end
            job_k.push_back(k);
            job_idle.push_back(idle);
            beats += k + idle;
            for (int b = 0; b < k; b++) begin
                for (int h = 0; h < HEIGHT; h++) begin
                    r = $fscanf(fd, "%d", v);
                    a_mem.push_back(data_t'(v));
                end
                for (int w = 0; w < WIDTH; w++) begin
                    r = $fscanf(fd, "%d", v);
                    b_mem.push_back(data_t'(v));
                end
            end
            for (int i = 0; i < HEIGHT*WIDTH; i++) begin
                if ($fscanf(fd, "%d", v) != 1) begin
                    $display("test file ends inside the expected values of job %0d", job_k.size());
                    good = 1'b0;
                end
                exp_mem.push_back(acc_t'(v));
            end
        end
        $fclose(fd);
        if (job_k.size() == 0) begin
            good = 1'b0;
        end
        // reset, every beat and idle cycle, each job's fill and drain, tail wait, slack.
        limit = 4 + beats + job_k.size() * (LAT + DRAIN_LEN) + 2*LAT + 50;
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset_i = 1'b0;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        in_last_i  = 1'b0;
        for (int h = 0; h < HEIGHT; h++) a_col_i[h] = '0;
        for (int w = 0; w < WIDTH; w++) b_row_i[w] = '0;
    endtask

    task automatic send_job(input int j, inout int beat);
        repeat (job_idle[j]) drive_idle();
        for (int k = 0; k < job_k[j]; k++) begin
            @(posedge clk);
            #1;
            in_valid_i = 1'b1;
            in_last_i  = (k == job_k[j] - 1);
            for (int h = 0; h < HEIGHT; h++) a_col_i[h] = a_mem[beat*HEIGHT + h];
            for (int w = 0; w < WIDTH; w++) b_row_i[w] = b_mem[beat*WIDTH + w];
            beat++;
        end
    endtask

    task automatic check_results();
        int base;
        check_value(rise_cycle.size(), job_k.size(), "number of c_valid_o windows");
        for (int j = 0; j < job_k.size(); j++) begin
            check_value(rise_cycle[j] - last_cycle[j], LAT,
                        $sformatf("job %0d c_valid_o delay after in_last_i", j));
            check_value(high_len[j], HEIGHT, $sformatf("job %0d c_valid_o length", j));
            for (int h = 0; h < HEIGHT; h++) begin
                for (int w = 0; w < WIDTH; w++) begin
                    base = (j*HEIGHT + h)*WIDTH + w;
                    check_value(got_rows[base], exp_mem[base],
                                $sformatf("job %0d C[%0d][%0d]", j, h, w));
                end
            end
        end
    endtask

    // outputs sampled mid cycle, away from both edges.
    initial begin : collector
        int   cycle;
        int   run;
        logic prev_valid;
        cycle      = 0;
        run        = 0;
        prev_valid = 1'b0;
        forever begin
            @(negedge clk);
            cycle++;
            if (reset_i !== 1'b1) begin
                if (in_valid_i && in_last_i) last_cycle.push_back(cycle);
                if (c_valid_o === 1'b1) begin
                    if (!prev_valid) begin
                        rise_cycle.push_back(cycle);
                        run = 0;
                    end
                    run++;
                    for (int w = 0; w < WIDTH; w++) got_rows.push_back(c_row_o[w]);
                end else if (prev_valid) begin
                    high_len.push_back(run);
                end
                prev_valid = (c_valid_o === 1'b1);
            end
        end
    end

    initial begin : watchdog
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("timeout: not all output rows arrived within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int beat;
        reset_i    = 1'b1;
        in_valid_i = 1'b0;
        in_last_i  = 1'b0;
        for (int h = 0; h < HEIGHT; h++) a_col_i[h] = '0;
        for (int w = 0; w < WIDTH; w++) b_row_i[w] = '0;
        beat = 0;
        load_tests(ok);
        if (!ok) begin
            $display("could not read usable jobs from %s", TEST_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            apply_reset();
            for (int j = 0; j < job_k.size(); j++) send_job(j, beat);
            drive_idle();
            while (high_len.size() < job_k.size()) @(negedge clk);
            repeat (2*LAT) @(negedge clk); // catch a stray extra window.
            check_results();
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== hdl/sa_top.sv ====
`timescale 1ns/100ps

module sa_top (
    input  logic               clk,
    input  logic               reset_i,

    // host side, one beat per valid cycle.
    input  logic               in_valid_i,
    input  logic               in_last_i,
    input  sa_geom_pkg::data_t a_col_i [sa_geom_pkg::HEIGHT],
    input  sa_geom_pkg::data_t b_row_i [sa_geom_pkg::WIDTH],

    // result rows, row 0 first.
    output sa_geom_pkg::acc_t  c_row_o [sa_geom_pkg::WIDTH],
    output logic               c_valid_o
);

    import sa_geom_pkg::*;

    logic      seq_en;
    logic      seq_clr;
    logic      seq_done;
    logic      drain;

    row_beat_t row_lane [HEIGHT];
    row_beat_t row_skew [HEIGHT];
    data_t     wght_skew [WIDTH];

    sa_sequencer u_seq (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .in_last_i  (in_last_i),
        .en_o       (seq_en),
        .clr_o      (seq_clr),
        .done_o     (seq_done),
        .drain_o    (drain)
    );

    // same strobes on every row, each with its own A element.
    for (genvar h = 0; h < HEIGHT; h++) begin : g_pack
        assign row_lane[h] = '{en: seq_en, clr: seq_clr, done: seq_done, ifm: a_col_i[h]};
    end

    skew_buffer #(
        .payload_t (row_beat_t),
        .LANES     (HEIGHT)
    ) u_ifm_skew (
        .clk     (clk),
        .reset_i (reset_i),
        .lane_i  (row_lane),
        .lane_o  (row_skew)
    );

    skew_buffer #(
        .payload_t (data_t),
        .LANES     (WIDTH)
    ) u_wght_skew (
        .clk     (clk),
        .reset_i (reset_i),
        .lane_i  (b_row_i),
        .lane_o  (wght_skew)
    );

    sa_array u_array (
        .clk     (clk),
        .reset_i (reset_i),
        .row_i   (row_skew),
        .wght_i  (wght_skew),
        .drain_i (drain),
        .ofm_o   (c_row_o)
    );

    // row 0 holds a valid result row for the whole drain window.
    assign c_valid_o = drain;

endmodule

// ==== hdl/sa_sequencer.sv ====
`timescale 1ns/100ps

module sa_sequencer (
    input  logic clk,
    input  logic reset_i,

    // host levels.
    input  logic in_valid_i,
    input  logic in_last_i,

    // row strobes, same cycle as the beat.
    output logic en_o,
    output logic clr_o,
    output logic done_o,

    // shared shift enable for the result registers.
    output logic drain_o
);

    import sa_ctrl_pkg::*;

    logic                first_q;
    logic [FILL_LAT-1:0] last_dly_q;
    drain_state_t        state_q;
    drain_cnt_t          cnt_q;

    // set until the first beat of a job is seen.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            first_q <= 1'b1;
        end else if (in_valid_i) begin
            first_q <= in_last_i; // re-arm after the last beat.
        end
    end

    assign en_o   = in_valid_i;
    assign clr_o  = in_valid_i & first_q;
    assign done_o = in_last_i;

    // job end travels until the far corner PE has loaded.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_dly_q <= '0;
        end else begin
            last_dly_q <= {last_dly_q[FILL_LAT-2:0], in_last_i};
        end
    end

    // drain window, one result row per cycle.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (last_dly_q[FILL_LAT-1]) begin
                        state_q <= ST_DRAIN;
                        cnt_q   <= drain_cnt_t'(DRAIN_LEN - 1);
                    end
                end
                ST_DRAIN: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign drain_o = (state_q == ST_DRAIN);

endmodule

// ==== hdl/skew_buffer.sv ====
`timescale 1ns/100ps

module skew_buffer #(
    parameter type payload_t = sa_geom_pkg::data_t,
    parameter int  LANES     = sa_geom_pkg::WIDTH
) (
    input  logic     clk,
    input  logic     reset_i,
    input  payload_t lane_i [LANES],
    output payload_t lane_o [LANES]
);

    // lane i is i+1 stages deep.
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        payload_t chain_q [i+1];

        always_ff @(posedge clk) begin
            if (reset_i) begin
                for (int s = 0; s <= i; s++) begin
                    chain_q[s] <= '0; // no stale strobe after reset.
                end
            end else begin
                chain_q[0] <= lane_i[i];
                for (int s = 1; s <= i; s++) begin
                    chain_q[s] <= chain_q[s-1];
                end
            end
        end

        assign lane_o[i] = chain_q[i];
    end

endmodule

// ==== array/sa_array.sv ====
`timescale 1ns/100ps

module sa_array (
    input  logic                   clk,
    input  logic                   reset_i,

    // one lane per row, entering at column 0.
    input  sa_geom_pkg::row_beat_t row_i [sa_geom_pkg::HEIGHT],

    // one lane per column, entering at row 0.
    input  sa_geom_pkg::data_t     wght_i [sa_geom_pkg::WIDTH],

    input  logic                   drain_i,

    // row 0 result registers.
    output sa_geom_pkg::acc_t      ofm_o [sa_geom_pkg::WIDTH]
);

    import sa_geom_pkg::*;

    // row_x[h][w] feeds PE(h,w); the extra slot is the open row end.
    row_beat_t row_x  [HEIGHT][WIDTH+1];

    // wght_x[w][h] feeds PE(h,w) from above.
    data_t     wght_x [WIDTH][HEIGHT+1];

    // ofm_x[w][h] is the result register of PE(h,w).
    // slot HEIGHT is the zero fed into the bottom row.
    acc_t      ofm_x  [WIDTH][HEIGHT+1];

    // left edge.
    for (genvar h = 0; h < HEIGHT; h++) begin : g_row_edge
        assign row_x[h][0] = row_i[h];
    end

    // top and bottom edges.
    for (genvar w = 0; w < WIDTH; w++) begin : g_col_edge
        assign wght_x[w][0]     = wght_i[w];
        assign ofm_x[w][HEIGHT] = '0;
        assign ofm_o[w]         = ofm_x[w][0];
    end

    for (genvar h = 0; h < HEIGHT; h++) begin : g_row
        for (genvar w = 0; w < WIDTH; w++) begin : g_col
            sa_pe u_pe (
                .clk     (clk),
                .reset_i (reset_i),

                .row_i   (row_x[h][w]),
                .row_o   (row_x[h][w+1]),

                .wght_i  (wght_x[w][h]),
                .wght_o  (wght_x[w][h+1]),

                .drain_i (drain_i),
                .ofm_i   (ofm_x[w][h+1]),
                .ofm_o   (ofm_x[w][h])
            );
        end
    end

endmodule

// ==== pe/sa_pe.sv ====
`timescale 1ns/100ps

module sa_pe (
    input  logic                   clk,
    input  logic                   reset_i,

    // feature lane, left to right.
    input  sa_geom_pkg::row_beat_t row_i,
    output sa_geom_pkg::row_beat_t row_o,

    // weight lane, top to bottom.
    input  sa_geom_pkg::data_t     wght_i,
    output sa_geom_pkg::data_t     wght_o,

    // output shift path, bottom to top.
    input  logic                   drain_i,
    input  sa_geom_pkg::acc_t      ofm_i,
    output sa_geom_pkg::acc_t      ofm_o
);

    import sa_geom_pkg::*;

    row_beat_t row_q;
    data_t     wght_q;
    acc_t      acc_q;
    acc_t      ofm_q;
    acc_t      prod;
    acc_t      sum;

    // both operands sign extended before the multiply.
    assign prod = acc_t'(row_i.ifm) * acc_t'(wght_i);

    // first beat of a job starts over.
    assign sum = row_i.clr ? prod : acc_q + prod;

    // forward paths, one hop per cycle.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            row_q <= '0;
        end else begin
            row_q <= row_i;
        end
    end

    always_ff @(posedge clk) begin
        wght_q <= wght_i;
    end

    // running sum.
    always_ff @(posedge clk) begin
        if (row_i.en) begin
            acc_q <= sum;
        end
    end

    // result register, independent of the accumulator so the
    // next job can run while this one is shifted out.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ofm_q <= '0;
        end else if (row_i.done) begin
            ofm_q <= sum; // includes the last product.
        end else if (drain_i) begin
            ofm_q <= ofm_i;
        end
    end

    assign row_o  = row_q;
    assign wght_o = wght_q;
    assign ofm_o  = ofm_q;

endmodule

// ==== common/sa_ctrl_pkg.sv ====
package sa_ctrl_pkg;

    // beat entering skew stage -> its load in the far corner PE.
    localparam int FILL_LAT  = sa_geom_pkg::HEIGHT + sa_geom_pkg::WIDTH - 1;

    // one output row per cycle.
    localparam int DRAIN_LEN = sa_geom_pkg::HEIGHT;

    // shortest spacing between two job ends, in beats.
    // the next done must not reach PE(0,0) before the previous drain is over,
    // which also keeps two drains apart.
    localparam int MIN_K     = FILL_LAT + DRAIN_LEN;

    typedef logic [$clog2(DRAIN_LEN)-1:0] drain_cnt_t;

    typedef enum logic {
        ST_IDLE,
        ST_DRAIN
    } drain_state_t;

endpackage

// ==== common/sa_geom_pkg.sv ====
package sa_geom_pkg;

    // array size.
    localparam int HEIGHT = 4;
    localparam int WIDTH  = 4;

    // operand and accumulator widths.
    localparam int IWIDTH = 8;
    localparam int OWIDTH = 24;

    typedef logic signed [IWIDTH-1:0] data_t;
    typedef logic signed [OWIDTH-1:0] acc_t;

    // one beat travelling along a row lane.
    // en qualifies the beat, clr marks the first beat of a job,
    // done marks the last one.
    typedef struct packed {
        logic  en;
        logic  clr;
        logic  done;
        data_t ifm;
    } row_beat_t;

endpackage
